/* peripheralSoc.f */
+incdir+common
common/socPkg.sv
hdl/busDecoder.sv
timer/timer.sv
hdl/ram.sv
hdl/interruptController.sv
hdl/readReturn.sv
hdl/peripheralSoc.sv
tests/peripheralSoc_chk.sv
tests/peripheralSoc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the peripheralSoc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f peripheralSoc.f \
    --top-module peripheralSoc_tb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* tests/peripheralSoc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module peripheralSoc_tb import socPkg::*; ();

    localparam int      clockPeriod     = 40;
    localparam int      timeoutCycles   = 4000;
    localparam int      ramWords        = 16;
    localparam int      partialWrites   = 32;
    localparam int      oneShotReload   = 20;
    localparam int      periodicReload  = 12;
    localparam addrT    pendingAddr     = intcBase + addrT'(intcPendingReg);
    localparam addrT    maskAddr        = intcBase + addrT'(intcMaskReg);
    localparam addrT    unmappedAddr    = 12'h300;

    logic   clk;
    logic   rstN;
    logic   read;
    logic   write;
    addrT   address;
    bweT    bwe;
    dataT   dataIn;
    logic   readValid;
    dataT   dataOut;
    logic   irq;

    // reference model of the ram words in use
    dataT   ramModel [addrT];
    addrT   ramAddr [ramWords];
    // expected read data in issue order
    dataT   expectQ [$];
    bit     compareQ [$];
    dataT   lastRead;
    int     seed = 26;
    int     cycleCount = 0;

    peripheralSoc DUT(
        .clk,
        .rstN,
        .read,
        .write,
        .address,
        .bwe,
        .dataIn,
        .readValid,
        .dataOut,
        .irq
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clockPeriod / 2) clk = ~clk;
        end
    end

    task automatic stopRun();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failValue(input string name, input dataT got, input dataT want);
        $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, want);
        stopRun();
    endtask

    task automatic failCheck(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stopRun();
    endtask

    // only the enabled byte lanes take the new data
    function automatic dataT mergeBytes(input dataT old, input dataT data, input bweT en);
        dataT merged;
        merged = old;
        for (int b = 0; b < $bits(bweT); b++) begin
            if (en[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic addrT timerAddr(input int n, input logic [1:0] r);
        return timerBase + addrT'(windowWords * n) + addrT'(r);
    endfunction

    task automatic busIdle();
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic busWrite(input addrT addr, input dataT data, input bweT en);
        @(posedge clk);
        read    <= 1'b0;
        write   <= 1'b1;
        address <= addr;
        dataIn  <= data;
        bwe     <= en;
    endtask

    task automatic busRead(input addrT addr, input dataT want, input bit compare);
        @(posedge clk);
        read    <= 1'b1;
        write   <= 1'b0;
        address <= addr;
        expectQ.push_back(want);
        compareQ.push_back(compare);
    endtask

    task automatic readExpect(input addrT addr, input dataT want);
        busRead(addr, want, 1'b1);
    endtask

    task automatic drainReads();
        while (expectQ.size() != 0) begin
            busIdle();
        end
    endtask

    task automatic readValue(input addrT addr, output dataT value);
        busRead(addr, '0, 1'b0);
        drainReads();
        value = lastRead;
    endtask

    // observe irq at negedges, at most limit of them
    task automatic waitIrq(input logic level, input int limit);
        int seen;
        seen = 1;
        busIdle();
        @(negedge clk);
        while (irq !== level) begin
            assert (seen < limit) else failCheck("irq did not reach the expected level in time");
            seen++;
            busIdle();
            @(negedge clk);
        end
    endtask

    // read return, sampled mid cycle
    always @(negedge clk) begin : readMonitor
        dataT   want;
        bit     compare;
        if (rstN && readValid && expectQ.size() != 0) begin
            want     = expectQ.pop_front();
            compare  = compareQ.pop_front();
            lastRead = dataOut;
            assert (!compare || dataOut == want) else failValue("dataOut", dataOut, want);
        end else begin
            assert (!(rstN && readValid)) else failCheck("readValid with no read outstanding");
        end
        assert (expectQ.size() <= 2) else failCheck("more than two reads in flight");
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < timeoutCycles) else failCheck("cycle limit reached, run timed out");
        assert (DUT.chk.failCount == 0) else failCheck("a bus protocol assertion failed");
    end

    initial begin
        dataT   value;
        dataT   data;
        bweT    en;
        addrT   addr;
        int     slot;
        int     polls;
        rstN    <= 1'b0;
        read    <= 1'b0;
        write   <= 1'b0;
        address <= '0;
        bwe     <= '0;
        dataIn  <= '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // quiet after reset
        @(negedge clk);
        assert (readValid === 1'b0) else failValue("readValid", dataT'(readValid), '0);
        assert (irq === 1'b0) else failValue("irq", dataT'(irq), '0);
        readExpect(pendingAddr, '0);
        readExpect(maskAddr, '0);
        for (int t = 0; t < `SOC_TIMER_COUNT; t++) begin
            readExpect(timerAddr(t, timerCountReg), '0);
        end
        drainReads();

        // ram, one word per 16-word stripe, full write first
        for (int i = 0; i < ramWords; i++) begin
            ramAddr[i] = addrT'(16 * i) + addrT'($random(seed) & 15);
            ramModel[ramAddr[i]] = $random(seed);
            busWrite(ramAddr[i], ramModel[ramAddr[i]], '1);
        end
        for (int i = 0; i < partialWrites; i++) begin
            slot = {$random(seed)} % ramWords;
            addr = ramAddr[slot];
            data = $random(seed);
            en   = bweT'($random(seed));
            ramModel[addr] = mergeBytes(ramModel[addr], data, en);
            busWrite(addr, data, en);
        end
        // back to back reads
        for (int i = 0; i < ramWords; i++) begin
            readExpect(ramAddr[i], ramModel[ramAddr[i]]);
        end
        drainReads();

        // unmapped space reads zero and ignores writes
        readExpect(unmappedAddr, '0);
        readExpect(12'hFFF, '0);
        readExpect(timerAddr(`SOC_TIMER_COUNT, timerCountReg), '0);
        readExpect(intcBase + addrT'(windowWords), '0);
        // same low offset as a live ram word
        busWrite(unmappedAddr | ramAddr[0], ~ramModel[ramAddr[0]], '1);
        // mask offset one window above the intc
        busWrite(intcBase + addrT'(windowWords) + addrT'(intcMaskReg), '1, '1);
        readExpect(ramAddr[0], ramModel[ramAddr[0]]);
        readExpect(maskAddr, '0);
        readExpect(pendingAddr, '0);
        drainReads();

        // one-shot timer 0, masked in
        busWrite(maskAddr, 32'h1, '1);
        busWrite(timerAddr(0, timerReloadReg), dataT'(oneShotReload), '1);
        busWrite(timerAddr(0, timerControlReg), 32'h1, '1);
        waitIrq(1'b1, oneShotReload + 4);
        readExpect(pendingAddr, 32'h1);
        readExpect(timerAddr(0, timerCountReg), '0);
        readExpect(timerAddr(0, timerControlReg), '0);
        readExpect(timerAddr(0, timerReloadReg), dataT'(oneShotReload));
        drainReads();

        // acknowledge drops irq
        busWrite(pendingAddr, 32'h1, '1);
        waitIrq(1'b0, 2);
        readExpect(pendingAddr, '0);
        drainReads();

        // timer 1 pends with its mask bit clear, irq stays low
        busWrite(timerAddr(1, timerReloadReg), dataT'(10), '1);
        busWrite(timerAddr(1, timerControlReg), 32'h1, '1);
        polls = 0;
        value = '0;
        while (!value[1]) begin
            assert (polls < 10) else failCheck("timer 1 never set its pending bit");
            readValue(pendingAddr, value);
            @(negedge clk);
            assert (irq === 1'b0) else failValue("irq", dataT'(irq), '0);
            polls++;
        end
        busWrite(pendingAddr, 32'h2, '1);
        readExpect(pendingAddr, '0);
        drainReads();

        // periodic timer 2 fires again after acknowledge
        busWrite(maskAddr, 32'h4, '1);
        busWrite(timerAddr(2, timerReloadReg), dataT'(periodicReload), '1);
        busWrite(timerAddr(2, timerControlReg), 32'h3, '1);
        waitIrq(1'b1, periodicReload + 4);
        busWrite(pendingAddr, 32'h4, '1);
        waitIrq(1'b0, 2);
        for (int i = 0; i < 4; i++) begin
            readValue(timerAddr(2, timerCountReg), value);
            assert (value <= dataT'(periodicReload))
                else failValue("timer 2 count against reload", value, dataT'(periodicReload));
        end
        waitIrq(1'b1, 2 * periodicReload);
        busWrite(timerAddr(2, timerControlReg), '0, '1);
        busWrite(pendingAddr, 32'h7, '1);
        busWrite(maskAddr, '0, '1);
        readExpect(pendingAddr, '0);
        readExpect(timerAddr(2, timerControlReg), '0);
        drainReads();
        busIdle();

        if (DUT.chk.failCount == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failCheck("a bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

/* tests/peripheralSoc_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module peripheralSoc_chk import socPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    read,
    input  logic    write,
    input  logic    readValid,
    input  logic    irq
);

    // count of failed properties
    int failCount = 0;

    // strobes are exclusive
    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN) !(read && write))
        else begin
            failCount++;
            $error("read and write high in the same cycle");
        end

    // fixed two-cycle read latency, both directions
    readLatency: assert property (@(posedge clk) disable iff (!rstN) read |-> ##2 readValid)
        else begin
            failCount++;
            $error("readValid missing two cycles after read");
        end

    readSource: assert property (@(posedge clk) disable iff (!rstN)
        readValid |-> $past(read, 2))
        else begin
            failCount++;
            $error("readValid without a read two cycles before");
        end

    irqInReset: assert property (@(posedge clk) !rstN |=> !irq)
        else begin
            failCount++;
            $error("irq high during reset");
        end

    for (genvar i = 0; i < `SOC_TIMER_COUNT; i++) begin : timerCheck
        // one-shot expiry leaves the timer stopped at zero
        stopAfterOneShot: assert property (@(posedge clk) disable iff (!rstN)
            timerGen[i].timer.expire && timerGen[i].timer.state == oneShot
            && !timerGen[i].timer.controlWrite
            |=> !timerGen[i].timer.running && timerGen[i].timer.count == '0)
            else begin
                failCount++;
                $error("one-shot timer still running after expiry");
            end

        // count frozen unless reloaded
        holdWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
            !timerGen[i].timer.running && !timerGen[i].timer.reloadWrite
            |=> $stable(timerGen[i].timer.count))
            else begin
                failCount++;
                $error("count moved while the timer was stopped");
            end
    end

endmodule

bind peripheralSoc peripheralSoc_chk chk (
    .clk,
    .rstN,
    .read,
    .write,
    .readValid,
    .irq
);

`default_nettype wire

/* hdl/peripheralSoc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module peripheralSoc import socPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        read,
    input  logic        write,
    input  addrT        address,
    input  bweT         bwe,
    input  dataT        dataIn,
    output logic        readValid,
    output dataT        dataOut,
    output logic        irq
);

    // decoder to slaves
    slaveReqT   ramReq;
    slaveReqT   timerReq [`SOC_TIMER_COUNT];
    slaveReqT   intcReq;
    slaveReqT   missReq;

    // slaves to read return
    slaveRspT   ramRsp;
    slaveRspT   timerRsp [`SOC_TIMER_COUNT];
    slaveRspT   intcRsp;

    // timer n drives interrupt n
    irqVecT     timerExpire;

    busDecoder
    busDecoder(
        .read,
        .write,
        .address,
        .dataIn,
        .bwe,
        .ramReq,
        .timerReq,
        .intcReq,
        .missReq
    );

    ram
    ram(
        .clk,
        .rstN,
        .req                    (ramReq),
        .rsp                    (ramRsp)
    );

    for (genvar i = 0; i < `SOC_TIMER_COUNT; i++) begin : timerGen
        timer
        timer(
            .clk,
            .rstN,
            .req                (timerReq[i]),
            .rsp                (timerRsp[i]),
            .expire             (timerExpire[i])
        );
    end

    interruptController
    interruptController(
        .clk,
        .rstN,
        .req                    (intcReq),
        .trigger                (timerExpire),
        .rsp                    (intcRsp),
        .irq
    );

    readReturn
    readReturn(
        .clk,
        .rstN,
        .ramRsp,
        .timerRsp,
        .intcRsp,
        .missReq,
        .readValid,
        .dataOut
    );

endmodule

`default_nettype wire

/* hdl/readReturn.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module readReturn import socPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  slaveRspT    ramRsp,
    input  slaveRspT    timerRsp [`SOC_TIMER_COUNT],
    input  slaveRspT    intcRsp,
    input  slaveReqT    missReq,
    output logic        readValid,
    output dataT        dataOut
);

    // data only counts when its valid is set
    function automatic dataT gated(input slaveRspT r);
        return r.valid ? r.data : '0;
    endfunction

    logic       missValid;
    slaveRspT   merged;

    // unmapped read, stands in for a slave stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            missValid <= 1'b0;
        end else begin
            missValid <= missReq.read;
        end
    end

    // one valid at most per cycle, plain OR is enough
    // the miss contributes zero data
    always_comb begin
        merged.valid = missValid | ramRsp.valid | intcRsp.valid;
        merged.data  = gated(ramRsp) | gated(intcRsp);
        for (int i = 0; i < `SOC_TIMER_COUNT; i++) begin
            merged.valid = merged.valid | timerRsp[i].valid;
            merged.data  = merged.data | gated(timerRsp[i]);
        end
    end

    // second read stage onto the bus
    always_ff @(posedge clk) begin
        dataOut <= merged.data;
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= merged.valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/interruptController.sv */
`timescale 1ns/1ps
`default_nettype none

module interruptController import socPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  slaveReqT    req,
    input  irqVecT      trigger,
    output slaveRspT    rsp,
    output logic        irq
);

    irqVecT     pending;
    irqVecT     mask;
    irqVecT     clearBits;
    logic       pendingWrite;
    logic       maskWrite;
    dataT       readData;

    assign pendingWrite = req.write && req.offset[1:0] == intcPendingReg;
    assign maskWrite    = req.write && req.offset[1:0] == intcMaskReg;

    // write-one-to-clear acknowledge
    assign clearBits = pendingWrite ? req.data[$bits(irqVecT)-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= '0;
            mask    <= '0;
        end else begin
            // new trigger beats a same-cycle acknowledge
            pending <= (pending & ~clearBits) | trigger;
            if (maskWrite) begin
                mask <= req.data[$bits(irqVecT)-1:0];
            end
        end
    end

    // request line, no extra register
    assign irq = |(pending & mask);

    always_comb begin
        case (req.offset[1:0])
            intcPendingReg: readData = dataT'(pending);
            intcMaskReg:    readData = dataT'(mask);
            default:        readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rsp.data <= readData;
        if (!rstN) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.read;
        end
    end

endmodule

`default_nettype wire

/* hdl/ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module ram import socPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  slaveReqT    req,
    output slaveRspT    rsp
);

    localparam int indexBits = $clog2(`SOC_RAM_DEPTH);

    dataT                   mem [`SOC_RAM_DEPTH];
    logic [indexBits-1:0]   index;

    // decoder already range checked, low offset bits index the array
    assign index = req.offset[indexBits-1:0];

    // byte lanes written only where bwe is set
    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int b = 0; b < $bits(bweT); b++) begin
                if (req.bwe[b]) begin
                    mem[index][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    // registered read, one cycle after the strobe
    always_ff @(posedge clk) begin
        rsp.data <= mem[index];
        if (!rstN) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.read;
        end
    end

endmodule

`default_nettype wire

/* timer/timer.sv */
`timescale 1ns/1ps
`default_nettype none

module timer import socPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  slaveReqT    req,
    output slaveRspT    rsp,
    output logic        expire
);

    timerStateT state;
    dataT       count;
    dataT       reload;
    dataT       readData;
    logic       running;
    logic       reloadWrite;
    logic       controlWrite;

    assign running      = state != stopped;
    assign reloadWrite  = req.write && req.offset[1:0] == timerReloadReg;
    assign controlWrite = req.write && req.offset[1:0] == timerControlReg;

    // pulse in the cycle the count leaves one
    // a reload write in that cycle cancels it
    assign expire = running && count == dataT'(1) && !reloadWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= stopped;
            count  <= '0;
            reload <= '0;
        end else begin
            // control write wins over the one-shot stop
            if (controlWrite) begin
                if (!req.data[ctrlEnableBit]) begin
                    state <= stopped;
                end else if (req.data[ctrlPeriodicBit]) begin
                    state <= periodic;
                end else begin
                    state <= oneShot;
                end
            end else if (expire && state == oneShot) begin
                state <= stopped;
            end

            // reload write loads both registers
            if (reloadWrite) begin
                reload <= req.data;
                count  <= req.data;
            end else if (expire) begin
                count <= (state == periodic) ? reload : '0;
            end else if (running && count != '0) begin
                count <= count - dataT'(1);
            end
        end
    end

    // register read mux, offset 3 reads zero
    always_comb begin
        case (req.offset[1:0])
            timerCountReg:   readData = count;
            timerReloadReg:  readData = reload;
            timerControlReg: readData = dataT'({state == periodic, running});
            default:         readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rsp.data <= readData;
        if (!rstN) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.read;
        end
    end

endmodule

`default_nettype wire

/* hdl/busDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module busDecoder import socPkg::*; (
    input  logic        read,
    input  logic        write,
    input  addrT        address,
    input  dataT        dataIn,
    input  bweT         bwe,
    output slaveReqT    ramReq,
    output slaveReqT    timerReq [`SOC_TIMER_COUNT],
    output slaveReqT    intcReq,
    output slaveReqT    missReq
);

    // keep payload, gate the strobes by the select
    function automatic slaveReqT steer(input slaveReqT base, input logic hit);
        slaveReqT gated;
        gated       = base;
        gated.read  = base.read & hit;
        gated.write = base.write & hit;
        return gated;
    endfunction

    slaveReqT   baseReq;
    addrT       ramWord;
    addrT       timerWord;
    addrT       intcWord;
    logic       ramHit;
    logic       timerHit;
    logic       intcHit;

    assign baseReq = '{read: read, write: write, offset: address[$bits(offsetT)-1:0],
                       data: dataIn, bwe: bwe};

    // word index relative to each window base
    assign ramWord   = address - ramBase;
    assign timerWord = address - timerBase;
    assign intcWord  = address - intcBase;

    // windows are disjoint, so at most one hit
    assign ramHit   = ramWord < addrT'(`SOC_RAM_DEPTH);
    assign timerHit = timerWord < addrT'(windowWords * `SOC_TIMER_COUNT);
    assign intcHit  = intcWord < addrT'(windowWords);

    always_comb begin
        ramReq  = steer(baseReq, ramHit);
        intcReq = steer(baseReq, intcHit);
        // nothing claims it, readReturn answers with zero
        missReq = steer(baseReq, !ramHit && !timerHit && !intcHit);
        // upper bits of the timer word pick the timer
        for (int i = 0; i < `SOC_TIMER_COUNT; i++) begin
            timerReq[i] = steer(baseReq, timerHit &&
                timerWord[`SOC_ADDR_WIDTH-1:2] == (`SOC_ADDR_WIDTH-2)'(i));
        end
    end

endmodule

`default_nettype wire

/* common/socPkg.sv */
`default_nettype none

`include "soc_settings.svh"

package socPkg;

    // bus vectors
    typedef logic [`SOC_ADDR_WIDTH-1:0]     addrT;
    typedef logic [`SOC_DATA_WIDTH-1:0]     dataT;
    typedef logic [`SOC_DATA_WIDTH/8-1:0]   bweT;
    // word offset inside a slave window
    typedef logic [7:0]                     offsetT;
    // one bit per interrupt source
    typedef logic [`SOC_TIMER_COUNT-1:0]    irqVecT;

    // request seen by every slave
    typedef struct packed {
        logic       read;
        logic       write;
        offsetT     offset;
        dataT       data;
        bweT        bwe;
    } slaveReqT;

    // registered read response from a slave
    typedef struct packed {
        logic       valid;
        dataT       data;
    } slaveRspT;

    typedef enum logic [1:0] {
        stopped,
        oneShot,
        periodic
    } timerStateT;

    // address map, word addresses
    localparam addrT        ramBase         = 12'h000;
    localparam addrT        timerBase       = 12'h100;
    localparam addrT        intcBase        = 12'h200;
    // timers and intc each own 4 words
    localparam int          windowWords     = 4;

    // timer registers
    localparam logic [1:0]  timerCountReg   = 2'd0;
    localparam logic [1:0]  timerReloadReg  = 2'd1;
    localparam logic [1:0]  timerControlReg = 2'd2;
    localparam int          ctrlEnableBit   = 0;
    localparam int          ctrlPeriodicBit = 1;

    // interrupt controller registers
    localparam logic [1:0]  intcPendingReg  = 2'd0;
    localparam logic [1:0]  intcMaskReg     = 2'd1;

endpackage

`default_nettype wire

/* common/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// word address, covers the whole 4K word map
`define SOC_ADDR_WIDTH      12

// bus word width
`define SOC_DATA_WIDTH      32

// timers in the bank, also the irq source count
`define SOC_TIMER_COUNT     3

// ram size in words
`define SOC_RAM_DEPTH       256

`endif
